//--- src/attn_params.svh
`ifndef ATTN_PARAMS_SVH
`define ATTN_PARAMS_SVH

// SRAM geometry
`define SRAM_ADDR_W 16
`define SRAM_DATA_W 32

// Matrix dimension fields, two per dims word
`define DIM_W 16

`endif

//--- src/attn_types_pkg.sv
`include "attn_params.svh"

package attn_types_pkg;

  typedef logic [`SRAM_DATA_W-1:0] word_t;  // One SRAM data word
  typedef logic [`DIM_W-1:0] dim_t;         // One matrix dimension

  // Controller phases
  typedef enum logic [2:0] {
    IDLE,
    READ_DIMS,     // Dims address on both SRAMs
    CAPTURE_DIMS,  // Dims data returned
    RUN_JOB,       // Start pulse to the engine
    WAIT_JOB       // Wait for engine done
  } phase_t;

  // Engine job kinds
  typedef enum logic [1:0] {
    PROJECT,  // Input times weight into result
    SCORE,    // Result times scratchpad into result
    COPY      // Result into scratchpad
  } job_kind_t;

endpackage

//--- src/attn_mem_pkg.sv
`include "attn_params.svh"

package attn_mem_pkg;

  typedef logic [`SRAM_ADDR_W-1:0] sram_addr_t;

  // One engine job as issued by the controller
  typedef struct packed {
    attn_types_pkg::job_kind_t kind;
    sram_addr_t a_base;     // Operand A, row-major
    sram_addr_t b_base;     // Operand B, contiguous per output column
    sram_addr_t dst_base;   // Destination, row-major
    attn_types_pkg::dim_t n_rows;
    attn_types_pkg::dim_t n_cols;
    attn_types_pkg::dim_t n_inner;
  } mac_job_t;

  // Input and weight SRAMs hold their dims word at address 0
  localparam sram_addr_t DIMS_ADDR = 16'd0;

  // Matrix data starts right after the dims word
  localparam sram_addr_t WEIGHT_BASE = 16'd1;

endpackage

//--- src/sram_port_if.sv
`timescale 1ns/1ns

// One SRAM port, read data returns one clock after the address
interface sram_port_if;
  attn_mem_pkg::sram_addr_t read_address;
  attn_types_pkg::word_t read_data;
  logic write_enable;
  attn_mem_pkg::sram_addr_t write_address;
  attn_types_pkg::word_t write_data;

  modport engine (
    output read_address, write_enable, write_address, write_data,
    input  read_data
  );

  modport monitor (
    input read_address, read_data, write_enable, write_address, write_data
  );
endinterface

// Job handoff between controller and engine
interface mac_job_if;
  logic start;                     // One cycle, job already valid
  attn_mem_pkg::mac_job_t job;     // Held until done
  logic done;                      // One cycle after the last write

  modport ctrl (output start, job, input done);
  modport engine (input start, job, output done);
endinterface

//--- src/attn_ctrl.sv
`timescale 1ns/1ns
`include "attn_params.svh"

module attn_ctrl (
  input  logic clk,
  input  logic reset_n,
  input  logic dut_valid,
  output logic dut_ready,
  sram_port_if.monitor input_port,
  sram_port_if.monitor weight_port,
  mac_job_if.ctrl job_bus
);

  // Job order within one run
  localparam logic [2:0] JOB_Q = 3'd0;
  localparam logic [2:0] JOB_K = 3'd1;
  localparam logic [2:0] JOB_V = 3'd2;
  localparam logic [2:0] JOB_COPY = 3'd3;
  localparam logic [2:0] JOB_S = 3'd4;

  attn_types_pkg::phase_t phase;
  logic [2:0] job_idx;
  attn_types_pkg::dim_t n_dim;  // Rows of X
  attn_types_pkg::dim_t d_dim;  // Columns of X, rows of W
  attn_types_pkg::dim_t e_dim;  // Columns of W
  attn_mem_pkg::sram_addr_t ne_size;
  attn_mem_pkg::sram_addr_t de_size;

  assign dut_ready = (phase == attn_types_pkg::IDLE);
  assign job_bus.start = (phase == attn_types_pkg::RUN_JOB);

  assign ne_size = n_dim * e_dim;  // One of Q, K, V in the result SRAM
  assign de_size = d_dim * e_dim;  // One weight matrix

  // Job descriptor from the memory map
  always_comb begin
    job_bus.job = '0;
    job_bus.job.kind = attn_types_pkg::PROJECT;
    job_bus.job.a_base = attn_mem_pkg::WEIGHT_BASE;  // X also starts after its dims word
    job_bus.job.b_base = attn_mem_pkg::WEIGHT_BASE;
    job_bus.job.n_rows = n_dim;
    job_bus.job.n_cols = e_dim;
    job_bus.job.n_inner = d_dim;
    case (job_idx)
      JOB_Q: job_bus.job.dst_base = '0;
      JOB_K: begin
        job_bus.job.b_base = attn_mem_pkg::WEIGHT_BASE + de_size;
        job_bus.job.dst_base = ne_size;
      end
      JOB_V: begin
        job_bus.job.b_base = attn_mem_pkg::WEIGHT_BASE + de_size + de_size;
        job_bus.job.dst_base = ne_size + ne_size;
      end
      JOB_COPY: begin
        job_bus.job.kind = attn_types_pkg::COPY;
        job_bus.job.a_base = ne_size;  // K in the result SRAM
        job_bus.job.dst_base = '0;
      end
      JOB_S: begin
        // Q row against K row, both e long
        job_bus.job.kind = attn_types_pkg::SCORE;
        job_bus.job.a_base = '0;
        job_bus.job.b_base = '0;
        job_bus.job.dst_base = ne_size + ne_size + ne_size;
        job_bus.job.n_cols = n_dim;
        job_bus.job.n_inner = e_dim;
      end
      default: job_bus.job.dst_base = '0;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      phase <= attn_types_pkg::IDLE;
      job_idx <= JOB_Q;
      n_dim <= '0;
      d_dim <= '0;
      e_dim <= '0;
    end else begin
      case (phase)
        attn_types_pkg::IDLE: begin
          if (dut_valid) begin
            phase <= attn_types_pkg::READ_DIMS;
            job_idx <= JOB_Q;
          end
        end
        attn_types_pkg::READ_DIMS: phase <= attn_types_pkg::CAPTURE_DIMS;
        attn_types_pkg::CAPTURE_DIMS: begin
          n_dim <= input_port.read_data[`SRAM_DATA_W-1 -: `DIM_W];
          d_dim <= input_port.read_data[`DIM_W-1:0];
          e_dim <= weight_port.read_data[`DIM_W-1:0];  // Upper half repeats d
          phase <= attn_types_pkg::RUN_JOB;
        end
        attn_types_pkg::RUN_JOB: phase <= attn_types_pkg::WAIT_JOB;
        attn_types_pkg::WAIT_JOB: begin
          if (job_bus.done) begin
            if (job_idx == JOB_S) begin
              phase <= attn_types_pkg::IDLE;
            end else begin
              job_idx <= job_idx + 3'd1;
              phase <= attn_types_pkg::RUN_JOB;
            end
          end
        end
        default: phase <= attn_types_pkg::IDLE;
      endcase
    end
  end

endmodule

//--- src/mac_engine.sv
`timescale 1ns/1ns

module mac_engine (
  input logic clk,
  input logic reset_n,
  mac_job_if.engine job_bus,
  sram_port_if.engine input_port,
  sram_port_if.engine weight_port,
  sram_port_if.engine result_port,
  sram_port_if.engine scratch_port
);

  typedef enum logic [2:0] {
    E_IDLE,
    E_ADDR,     // Operand addresses out
    E_ACC,      // Operand data back, accumulate
    E_WRITE,    // Store one output element
    E_COPY_RD,
    E_COPY_WR
  } engine_state_t;

  engine_state_t state;
  attn_types_pkg::dim_t row_cnt;
  attn_types_pkg::dim_t col_cnt;
  attn_types_pkg::dim_t k_cnt;
  attn_mem_pkg::sram_addr_t copy_idx;
  attn_types_pkg::word_t acc;
  attn_types_pkg::word_t product;
  logic done_r;
  logic is_project;
  attn_types_pkg::dim_t last_row;
  attn_types_pkg::dim_t last_col;
  attn_types_pkg::dim_t last_inner;
  attn_mem_pkg::sram_addr_t copy_last;
  attn_mem_pkg::sram_addr_t a_addr;
  attn_mem_pkg::sram_addr_t b_addr;
  attn_mem_pkg::sram_addr_t dst_addr;

  assign job_bus.done = done_r;
  assign is_project = (job_bus.job.kind == attn_types_pkg::PROJECT);

  assign last_row = job_bus.job.n_rows - 16'd1;
  assign last_col = job_bus.job.n_cols - 16'd1;
  assign last_inner = job_bus.job.n_inner - 16'd1;
  assign copy_last = job_bus.job.n_rows * job_bus.job.n_cols - 16'd1;

  assign a_addr = job_bus.job.a_base + row_cnt * job_bus.job.n_inner + k_cnt;
  assign b_addr = job_bus.job.b_base + col_cnt * job_bus.job.n_inner + k_cnt;
  assign dst_addr = job_bus.job.dst_base + row_cnt * job_bus.job.n_cols + col_cnt;

  // Low 32 bits of the operand product
  assign product = is_project ? input_port.read_data * weight_port.read_data
                              : result_port.read_data * scratch_port.read_data;

  // Port drive; idle reads park on the dims word
  always_comb begin
    input_port.read_address = attn_mem_pkg::DIMS_ADDR;
    weight_port.read_address = attn_mem_pkg::DIMS_ADDR;
    result_port.read_address = attn_mem_pkg::DIMS_ADDR;
    scratch_port.read_address = attn_mem_pkg::DIMS_ADDR;
    input_port.write_enable = 1'b0;   // Input and weight are read only
    input_port.write_address = '0;
    input_port.write_data = '0;
    weight_port.write_enable = 1'b0;
    weight_port.write_address = '0;
    weight_port.write_data = '0;
    result_port.write_enable = 1'b0;
    result_port.write_address = '0;
    result_port.write_data = '0;
    scratch_port.write_enable = 1'b0;
    scratch_port.write_address = '0;
    scratch_port.write_data = '0;
    case (state)
      E_ADDR: begin
        if (is_project) begin
          input_port.read_address = a_addr;
          weight_port.read_address = b_addr;
        end else begin
          result_port.read_address = a_addr;  // Q row
          scratch_port.read_address = b_addr; // K row from the copy
        end
      end
      E_WRITE: begin
        result_port.write_enable = 1'b1;
        result_port.write_address = dst_addr;
        result_port.write_data = acc;
      end
      E_COPY_RD: result_port.read_address = job_bus.job.a_base + copy_idx;
      E_COPY_WR: begin
        scratch_port.write_enable = 1'b1;
        scratch_port.write_address = job_bus.job.dst_base + copy_idx;
        scratch_port.write_data = result_port.read_data;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= E_IDLE;
      row_cnt <= '0;
      col_cnt <= '0;
      k_cnt <= '0;
      copy_idx <= '0;
      done_r <= 1'b0;
    end else begin
      done_r <= 1'b0;
      case (state)
        E_IDLE: begin
          if (job_bus.start) begin
            row_cnt <= '0;
            col_cnt <= '0;
            k_cnt <= '0;
            copy_idx <= '0;
            state <= (job_bus.job.kind == attn_types_pkg::COPY) ? E_COPY_RD : E_ADDR;
          end
        end
        E_ADDR: state <= E_ACC;
        E_ACC: begin
          k_cnt <= k_cnt + 16'd1;
          state <= (k_cnt == last_inner) ? E_WRITE : E_ADDR;
        end
        E_WRITE: begin
          k_cnt <= '0;
          state <= E_ADDR;
          if (col_cnt == last_col) begin
            col_cnt <= '0;
            if (row_cnt == last_row) begin
              state <= E_IDLE;
              done_r <= 1'b1;
            end else begin
              row_cnt <= row_cnt + 16'd1;
            end
          end else begin
            col_cnt <= col_cnt + 16'd1;
          end
        end
        E_COPY_RD: state <= E_COPY_WR;
        E_COPY_WR: begin
          if (copy_idx == copy_last) begin
            state <= E_IDLE;
            done_r <= 1'b1;
          end else begin
            copy_idx <= copy_idx + 16'd1;
            state <= E_COPY_RD;
          end
        end
        default: state <= E_IDLE;
      endcase
    end
  end

  // Dot product accumulator, cleared between elements
  always_ff @(posedge clk) begin
    if (state == E_ACC) begin
      acc <= acc + product;
    end else if (state == E_WRITE || state == E_IDLE) begin
      acc <= '0;
    end
  end

endmodule

//--- src/attn_top.sv
`timescale 1ns/1ns

module attn_top (
  input  logic clk,
  input  logic reset_n,
  input  logic dut_valid,
  output logic dut_ready,

  output attn_mem_pkg::sram_addr_t sram_input_read_address,
  input  attn_types_pkg::word_t    sram_input_read_data,

  output attn_mem_pkg::sram_addr_t sram_weight_read_address,
  input  attn_types_pkg::word_t    sram_weight_read_data,

  output attn_mem_pkg::sram_addr_t sram_result_read_address,
  input  attn_types_pkg::word_t    sram_result_read_data,
  output logic                     sram_result_write_enable,
  output attn_mem_pkg::sram_addr_t sram_result_write_address,
  output attn_types_pkg::word_t    sram_result_write_data,

  output attn_mem_pkg::sram_addr_t sram_scratchpad_read_address,
  input  attn_types_pkg::word_t    sram_scratchpad_read_data,
  output logic                     sram_scratchpad_write_enable,
  output attn_mem_pkg::sram_addr_t sram_scratchpad_write_address,
  output attn_types_pkg::word_t    sram_scratchpad_write_data
);

  sram_port_if input_port ();
  sram_port_if weight_port ();
  sram_port_if result_port ();
  sram_port_if scratch_port ();
  mac_job_if job_bus ();

  // Input and weight are wired for reads only
  assign sram_input_read_address = input_port.read_address;
  assign input_port.read_data = sram_input_read_data;
  assign sram_weight_read_address = weight_port.read_address;
  assign weight_port.read_data = sram_weight_read_data;

  assign sram_result_read_address = result_port.read_address;
  assign result_port.read_data = sram_result_read_data;
  assign sram_result_write_enable = result_port.write_enable;
  assign sram_result_write_address = result_port.write_address;
  assign sram_result_write_data = result_port.write_data;

  assign sram_scratchpad_read_address = scratch_port.read_address;
  assign scratch_port.read_data = sram_scratchpad_read_data;
  assign sram_scratchpad_write_enable = scratch_port.write_enable;
  assign sram_scratchpad_write_address = scratch_port.write_address;
  assign sram_scratchpad_write_data = scratch_port.write_data;

  attn_ctrl u_ctrl (
    .clk         (clk),
    .reset_n     (reset_n),
    .dut_valid   (dut_valid),
    .dut_ready   (dut_ready),
    .input_port  (input_port.monitor),
    .weight_port (weight_port.monitor),
    .job_bus     (job_bus.ctrl)
  );

  mac_engine u_engine (
    .clk          (clk),
    .reset_n      (reset_n),
    .job_bus      (job_bus.engine),
    .input_port   (input_port.engine),
    .weight_port  (weight_port.engine),
    .result_port  (result_port.engine),
    .scratch_port (scratch_port.engine)
  );

endmodule

//--- testbench/attn_asserts.sv
`timescale 1ns/1ns

module attn_asserts (
  input logic clk,
  input logic reset_n,
  input logic dut_valid,
  input logic dut_ready,
  input logic result_we,
  input logic scratch_we
);

  int fail_count = 0;

  // Engine is idle whenever the top level is ready
  a_no_write_while_ready: assert property (@(posedge clk) disable iff (!reset_n)
    dut_ready |-> !(result_we || scratch_we))
    else begin
      fail_count++;
      $error("SRAM write enable high while dut_ready is high");
    end

  // Accepted start drops ready on the next edge
  a_ready_falls: assert property (@(posedge clk) disable iff (!reset_n)
    (dut_valid && dut_ready) |=> !dut_ready)
    else begin
      fail_count++;
      $error("dut_ready still high after an accepted dut_valid");
    end

  a_single_writer: assert property (@(posedge clk) disable iff (!reset_n)
    !(result_we && scratch_we))
    else begin
      fail_count++;
      $error("result and scratchpad written in the same cycle");
    end

endmodule

bind attn_top attn_asserts u_asserts (
  .clk        (clk),
  .reset_n    (reset_n),
  .dut_valid  (dut_valid),
  .dut_ready  (dut_ready),
  .result_we  (sram_result_write_enable),
  .scratch_we (sram_scratchpad_write_enable)
);

//--- testbench/tb_attn.sv
`timescale 1ns/1ns
`include "attn_params.svh"

module tb_attn;

  localparam int MEM_DEPTH = 1 << `SRAM_ADDR_W;
  localparam int NUM_RUNS = 8;
  localparam int RUN_TIMEOUT = 2000;  // The largest run needs about 650 cycles

  logic clk;
  logic reset_n;
  logic dut_valid;
  logic dut_ready;
  logic fill_en;
  logic [15:0] fill_salt;

  attn_mem_pkg::sram_addr_t input_raddr;
  attn_mem_pkg::sram_addr_t weight_raddr;
  attn_mem_pkg::sram_addr_t result_raddr;
  attn_mem_pkg::sram_addr_t result_waddr;
  attn_mem_pkg::sram_addr_t scratch_raddr;
  attn_mem_pkg::sram_addr_t scratch_waddr;
  attn_types_pkg::word_t input_rdata = '0;
  attn_types_pkg::word_t weight_rdata = '0;
  attn_types_pkg::word_t result_rdata = '0;
  attn_types_pkg::word_t scratch_rdata = '0;
  attn_types_pkg::word_t result_wdata;
  attn_types_pkg::word_t scratch_wdata;
  logic result_we;
  logic scratch_we;

  attn_types_pkg::word_t input_mem [MEM_DEPTH];
  attn_types_pkg::word_t weight_mem [MEM_DEPTH];
  attn_types_pkg::word_t result_mem [MEM_DEPTH];
  attn_types_pkg::word_t scratch_mem [MEM_DEPTH];

  attn_top uut (
    .clk                           (clk),
    .reset_n                       (reset_n),
    .dut_valid                     (dut_valid),
    .dut_ready                     (dut_ready),
    .sram_input_read_address       (input_raddr),
    .sram_input_read_data          (input_rdata),
    .sram_weight_read_address      (weight_raddr),
    .sram_weight_read_data         (weight_rdata),
    .sram_result_read_address      (result_raddr),
    .sram_result_read_data         (result_rdata),
    .sram_result_write_enable      (result_we),
    .sram_result_write_address     (result_waddr),
    .sram_result_write_data        (result_wdata),
    .sram_scratchpad_read_address  (scratch_raddr),
    .sram_scratchpad_read_data     (scratch_rdata),
    .sram_scratchpad_write_enable  (scratch_we),
    .sram_scratchpad_write_address (scratch_waddr),
    .sram_scratchpad_write_data    (scratch_wdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic attn_mem_pkg::sram_addr_t to_addr(input int a);
    return attn_mem_pkg::sram_addr_t'(a);
  endfunction

  // SRAM models with one-cycle reads
  always @(posedge clk) begin
    input_rdata <= input_mem[input_raddr];
    weight_rdata <= weight_mem[weight_raddr];
    result_rdata <= result_mem[result_raddr];
    scratch_rdata <= scratch_mem[scratch_raddr];
    if (fill_en) begin
      for (int a = 0; a < MEM_DEPTH; a++) begin
        result_mem[to_addr(a)] <= {fill_salt, to_addr(a)};  // Stale words never match
        scratch_mem[to_addr(a)] <= ~{fill_salt, to_addr(a)};
      end
    end else begin
      if (result_we) result_mem[result_waddr] <= result_wdata;
      if (scratch_we) scratch_mem[scratch_waddr] <= scratch_wdata;
    end
  end

  task automatic abort_test();
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_problem(input string what);
    $display("Error at %0t ns: %s", $time, what);
    abort_test();
  endtask

  always @(negedge clk) begin
    if (uut.u_asserts.fail_count != 0) begin
      report_problem("a bound protocol assertion failed");
    end
  end

  task automatic check_word(input string name, input int addr,
                            input attn_types_pkg::word_t expected,
                            input attn_types_pkg::word_t actual);
    assert (actual === expected) else begin
      $display("Mismatch at %0t ns: %s[%0d] expected %h, got %h",
               $time, name, addr, expected, actual);
      abort_test();
    end
  endtask

  // Dims words plus random X and W_q, W_k, W_v
  task automatic load_operands(input int n, input int d, input int e);
    input_mem[0] = {16'(n), 16'(d)};
    weight_mem[0] = {16'(d), 16'(e)};
    for (int a = 1; a <= n * d; a++) input_mem[to_addr(a)] = $urandom;
    for (int a = 1; a <= 3 * d * e; a++) weight_mem[to_addr(a)] = $urandom;
  endtask

  task automatic clear_outputs();
    fill_salt = 16'($urandom);
    fill_en = 1'b1;
    @(negedge clk);
    fill_en = 1'b0;
  endtask

  task automatic start_run();
    assert (dut_ready === 1'b1) else report_problem("dut_ready low before a new run");
    dut_valid = 1'b1;
    @(negedge clk);
    dut_valid = 1'b0;
    assert (dut_ready === 1'b0) else report_problem("dut_ready did not fall after start");
  endtask

  task automatic wait_for_ready(input bit pulse_mid_run);
    int cycles;
    cycles = 0;
    while (dut_ready !== 1'b1) begin
      if (cycles >= RUN_TIMEOUT) begin
        report_problem("timeout, dut_ready did not rise at the end of the run");
      end
      dut_valid = pulse_mid_run && (cycles == 4);  // Must be ignored while busy
      @(negedge clk);
      cycles++;
    end
    dut_valid = 1'b0;
  endtask

  // Reference model straight from the memory map
  task automatic check_results(input int n, input int d, input int e);
    attn_types_pkg::word_t q [16];
    attn_types_pkg::word_t kmat [16];
    attn_types_pkg::word_t sum;
    int ne;
    ne = n * e;
    for (int m = 0; m < 3; m++) begin
      for (int i = 0; i < n; i++) begin
        for (int j = 0; j < e; j++) begin
          sum = '0;
          for (int k = 0; k < d; k++) begin
            sum = sum + input_mem[to_addr(1 + i * d + k)]
                      * weight_mem[to_addr(1 + m * d * e + j * d + k)];
          end
          check_word("result_mem", m * ne + i * e + j, sum,
                     result_mem[to_addr(m * ne + i * e + j)]);
          if (m == 0) q[i * e + j] = sum;
          if (m == 1) kmat[i * e + j] = sum;
        end
      end
    end
    for (int a = 0; a < ne; a++) begin
      check_word("scratch_mem", a, kmat[a], scratch_mem[to_addr(a)]);
    end
    for (int i = 0; i < n; i++) begin
      for (int j = 0; j < n; j++) begin
        sum = '0;
        for (int k = 0; k < e; k++) sum = sum + q[i * e + k] * kmat[j * e + k];
        check_word("result_mem", 3 * ne + i * n + j, sum,
                   result_mem[to_addr(3 * ne + i * n + j)]);
      end
    end
  endtask

  task automatic do_run(input int run_idx);
    int n;
    int d;
    int e;
    n = 1 + int'($urandom % 4);
    d = 1 + int'($urandom % 4);
    e = 1 + int'($urandom % 4);
    $display("Run %0d: n=%0d d=%0d e=%0d", run_idx, n, d, e);
    load_operands(n, d, e);
    clear_outputs();
    start_run();
    wait_for_ready(run_idx % 2 == 1);
    check_results(n, d, e);
  endtask

  initial begin
    reset_n = 1'b0;
    dut_valid = 1'b0;
    fill_en = 1'b0;
    fill_salt = '0;
    void'($urandom(32'hd594));
    repeat (3) @(negedge clk);
    reset_n = 1'b1;
    @(negedge clk);
    assert (dut_ready === 1'b1) else report_problem("dut_ready is not high after reset");
    assert (result_we === 1'b0 && scratch_we === 1'b0)
      else report_problem("a write enable is high after reset");
    for (int run = 0; run < NUM_RUNS; run++) begin
      do_run(run);
    end
    if (uut.u_asserts.fail_count == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      report_problem("a bound protocol assertion failed");
    end
  end

endmodule

//--- project.f
+incdir+src
src/attn_types_pkg.sv
src/attn_mem_pkg.sv
src/sram_port_if.sv
src/attn_ctrl.sv
src/mac_engine.sv
src/attn_top.sv
testbench/attn_asserts.sv
testbench/tb_attn.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert
TOP        ?= tb_attn
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
PASS_MSG   := TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
